/* verilog/soc_map_pkg.sv */
// address map of the peripheral side
package soc_map_pkg;

    // on-chip scratch RAM window
    localparam logic [63:0] ram_base = 64'h0000_0000_8000_0000;
    // bytes, one word per 4 bytes
    localparam logic [63:0] ram_bytes = 64'h0000_0000_0000_1000;

    // machine timer, two fixed addresses
    localparam logic [63:0] mtime_addr = 64'h0000_0000_0200_BFF8;
    localparam logic [63:0] mtimecmp_addr = 64'h0000_0000_0200_4000;
    // compare value out of reset
    localparam logic [63:0] mtimecmp_reset = 64'h0000_0000_8000_0000;

    // PLIC window
    // priority of source id sits at base + 4 * id
    localparam logic [63:0] plic_base = 64'h0000_0000_0C00_0000;

    // offsets from plic_base
    // global pending bitmap
    localparam logic [63:0] plic_pending_off = 64'h0000_1000;
    // enable word of context 0
    localparam logic [63:0] plic_enable_off = 64'h0000_2000;
    // threshold of context 0
    localparam logic [63:0] plic_threshold_off = 64'h0020_0000;
    // claim of context 0
    localparam logic [63:0] plic_claim_off = 64'h0020_0004;

    // per context spacing
    // threshold and claim
    localparam logic [63:0] plic_ctx_stride = 64'h0000_1000;
    // enable words
    localparam logic [63:0] plic_enable_stride = 64'h0000_0080;

    // number of interrupt sources, id 0 unused
    localparam int plic_sources = 6;

endpackage

/* verilog/bus_pkg.sv */
// CPU-style bus seen by the peripherals
package bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // load/store width codes as issued by the core
    // bit 2 set means zero extension on loads
    typedef enum logic [2:0] {
        ls_b  = 3'b000,
        ls_h  = 3'b001,
        ls_w  = 3'b010,
        ls_d  = 3'b011,
        ls_bu = 3'b100,
        ls_hu = 3'b101,
        ls_wu = 3'b110
    } ls_type_t;

    // master side of the bus
    // addr and wdata held stable until done rises
    // read_en and write_en are one-cycle pulses
    typedef struct packed {
        dword_t   addr;
        dword_t   wdata;
        ls_type_t ls_type;
        logic     read_en;
        logic     write_en;
    } bus_req_t;

    // slave side of the bus
    // done levels sit high while idle
    typedef struct packed {
        dword_t rdata;
        logic   read_done;
        logic   write_done;
    } bus_rsp_t;

    // target chosen by the address decoder
    typedef enum logic [1:0] {
        tgt_none  = 2'd0,
        tgt_ram   = 2'd1,
        tgt_timer = 2'd2,
        tgt_plic  = 2'd3
    } target_t;

endpackage

/* verilog/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram #(
    parameter int ram_words = 1024
) (
    input  logic              CLOCK_50,
    input  bus_pkg::bus_req_t req,
    input  logic              sel,
    input  logic              rd_stb,
    input  logic              wr_stb,
    input  logic              step,
    output logic              ack,
    output bus_pkg::dword_t   rdata
);

    localparam int addr_w = $clog2(ram_words);

    bus_pkg::word_t  mem [ram_words];
    bus_pkg::dword_t off;
    logic [addr_w-1:0] idx;
    logic [4:0]      lane_sh;
    logic            is_dword;
    bus_pkg::word_t  rword;
    bus_pkg::word_t  rshift;
    bus_pkg::dword_t load_ext;
    bus_pkg::word_t  wword;
    logic [3:0]      wmask;

    // word index from the byte offset, step picks the upper word
    assign off     = req.addr - soc_map_pkg::ram_base;
    assign idx     = off[addr_w+1:2] + addr_w'(step);
    assign lane_sh = {req.addr[1:0], 3'b000};
    assign is_dword = (req.ls_type == bus_pkg::ls_d);

    // store lanes
    always_comb begin
        wword = req.wdata[31:0] << lane_sh;
        case (req.ls_type)
            bus_pkg::ls_b: wmask = 4'b0001 << req.addr[1:0];
            bus_pkg::ls_h: wmask = 4'b0011 << req.addr[1:0];
            bus_pkg::ls_d: begin
                // low word at step 0, high word at step 1
                wmask = 4'b1111;
                wword = step ? req.wdata[63:32] : req.wdata[31:0];
            end
            default: begin
                wmask = 4'b1111;
                wword = req.wdata[31:0];
            end
        endcase
    end

    // load alignment and extension
    assign rword  = mem[idx];
    assign rshift = rword >> lane_sh;

    always_comb begin
        case (req.ls_type)
            bus_pkg::ls_b:  load_ext = {{56{rshift[7]}}, rshift[7:0]};
            bus_pkg::ls_h:  load_ext = {{48{rshift[15]}}, rshift[15:0]};
            bus_pkg::ls_bu: load_ext = {56'b0, rshift[7:0]};
            bus_pkg::ls_hu: load_ext = {48'b0, rshift[15:0]};
            bus_pkg::ls_wu: load_ext = {32'b0, rshift};
            // lw
            default:        load_ext = {{32{rshift[31]}}, rshift};
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        // one cycle after every strobe
        ack <= sel & (rd_stb | wr_stb);
        if (sel && wr_stb) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) begin
                    mem[idx][8*i +: 8] <= wword[8*i +: 8];
                end
            end
        end
        if (sel && rd_stb) begin
            if (is_dword) begin
                // ld builds the dword over two steps
                if (step) begin
                    rdata[63:32] <= rword;
                end else begin
                    rdata[31:0] <= rword;
                end
            end else begin
                rdata <= load_ext;
            end
        end
    end

endmodule

/* verilog/machine_timer.sv */
`timescale 1ns/1ps

module machine_timer (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t req,
    input  logic              sel,
    input  logic              wr_stb,
    output bus_pkg::dword_t   mtime,
    output bus_pkg::dword_t   mtimecmp,
    output bus_pkg::dword_t   rdata
);

    logic cmp_hit;

    assign cmp_hit = (req.addr == soc_map_pkg::mtimecmp_addr);

    // free-running time base
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // compare register, mtime writes are dropped
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtimecmp <= soc_map_pkg::mtimecmp_reset;
        end else if (sel && wr_stb && cmp_hit) begin
            mtimecmp <= req.wdata;
        end
    end

    // read in the strobe cycle
    assign rdata = cmp_hit ? mtimecmp : mtime;

endmodule

/* verilog/plic_regs.sv */
`timescale 1ns/1ps

module plic_regs (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t req,
    input  logic              sel,
    input  logic              rd_stb,
    input  logic              wr_stb,
    input  logic              ext_irq,
    output bus_pkg::word_t    rdata,
    output logic              meip,
    output logic              msip
);

    localparam int id_w = $clog2(soc_map_pkg::plic_sources);
    // priority array spans 4 bytes per source
    localparam bus_pkg::dword_t prio_span = bus_pkg::dword_t'(soc_map_pkg::plic_sources * 4);

    logic [2:0]      prio [soc_map_pkg::plic_sources];
    bus_pkg::word_t  pending;
    bus_pkg::word_t  enable [2];
    logic [2:0]      threshold [2];
    bus_pkg::word_t  claim [2];
    logic            irq_q;
    logic            irq_rise;
    bus_pkg::dword_t off;
    logic [id_w-1:0] prio_id;
    logic            prio_hit;
    logic            pend_hit;
    logic [1:0]      en_hit;
    logic [1:0]      thr_hit;
    logic [1:0]      clm_hit;
    logic            rd;
    logic            wr;

    assign off      = req.addr - soc_map_pkg::plic_base;
    assign prio_id  = off[id_w+1:2];
    assign prio_hit = (off < prio_span);
    assign pend_hit = (off == soc_map_pkg::plic_pending_off);
    assign rd       = sel & rd_stb;
    assign wr       = sel & wr_stb;
    assign irq_rise = ext_irq & ~irq_q;

    // per context decode and claim id
    // only source 1 is wired, so the id is 1 or 0
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            en_hit[c]  = (off == soc_map_pkg::plic_enable_off + c * soc_map_pkg::plic_enable_stride);
            thr_hit[c] = (off == soc_map_pkg::plic_threshold_off + c * soc_map_pkg::plic_ctx_stride);
            clm_hit[c] = (off == soc_map_pkg::plic_claim_off + c * soc_map_pkg::plic_ctx_stride);
            claim[c]   = (pending[1] && enable[c][1]) ? 32'd1 : 32'd0;
        end
    end

    // threshold is not compared against priority
    assign meip = (claim[0] != 32'd0);
    assign msip = (claim[1] != 32'd0);

    // read mux, unknown offsets read zero
    always_comb begin
        rdata = '0;
        if (prio_hit) begin
            rdata = 32'(prio[prio_id]);
        end else if (pend_hit) begin
            rdata = pending;
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (en_hit[c]) rdata = enable[c];
                if (thr_hit[c]) rdata = 32'(threshold[c]);
                if (clm_hit[c]) rdata = claim[c];
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < soc_map_pkg::plic_sources; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
            pending <= '0;
            irq_q   <= 1'b0;
        end else begin
            irq_q <= ext_irq;
            if (wr && prio_hit) begin
                prio[prio_id] <= req.wdata[2:0];
            end
            for (int c = 0; c < 2; c++) begin
                if (wr && en_hit[c]) enable[c] <= req.wdata[31:0];
                if (wr && thr_hit[c]) threshold[c] <= req.wdata[2:0];
                // claim read retires the pending source
                if (rd && clm_hit[c] && claim[c] != 32'd0) pending[claim[c][4:0]] <= 1'b0;
            end
            // new edge on the external line beats a same-cycle claim
            if (irq_rise) begin
                pending[1] <= 1'b1;
            end
        end
    end

endmodule

/* verilog/bus_sequencer.sv */
`timescale 1ns/1ps

module bus_sequencer #(
    parameter int ram_words = 1024
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t bus_req,
    output bus_pkg::bus_rsp_t bus_rsp,
    output bus_pkg::target_t  tgt_sel,
    output logic              rd_stb,
    output logic              wr_stb,
    output logic              step,
    input  logic              ram_ack,
    input  bus_pkg::dword_t   ram_rdata,
    input  bus_pkg::dword_t   tmr_rdata,
    input  bus_pkg::word_t    plic_rdata
);

    // end of the RAM window, follows the configured depth
    localparam bus_pkg::dword_t ram_top =
        soc_map_pkg::ram_base + bus_pkg::dword_t'(ram_words) * 4;
    // PLIC window ends after the context 1 threshold/claim page
    localparam bus_pkg::dword_t plic_top = soc_map_pkg::plic_base
        + soc_map_pkg::plic_threshold_off + 2 * soc_map_pkg::plic_ctx_stride;

    logic            rd_pend;
    logic            wr_pend;
    logic            hold_q;
    logic            stb_q;
    logic            step_q;
    logic            busy;
    logic            start;
    logic            fin;
    logic            second;
    logic            is_dword;
    bus_pkg::dword_t sel_rdata;
    bus_pkg::dword_t rdata_q;

    // address decode, addr is held stable for the whole access
    always_comb begin
        if (bus_req.addr >= soc_map_pkg::ram_base && bus_req.addr < ram_top) begin
            tgt_sel = bus_pkg::tgt_ram;
        end else if (bus_req.addr == soc_map_pkg::mtime_addr ||
                     bus_req.addr == soc_map_pkg::mtimecmp_addr) begin
            tgt_sel = bus_pkg::tgt_timer;
        end else if (bus_req.addr >= soc_map_pkg::plic_base && bus_req.addr < plic_top) begin
            tgt_sel = bus_pkg::tgt_plic;
        end else begin
            tgt_sel = bus_pkg::tgt_none;
        end
    end

    assign busy     = rd_pend | wr_pend;
    assign start    = (bus_req.read_en | bus_req.write_en) & ~busy;
    assign is_dword = (bus_req.ls_type == bus_pkg::ls_d);
    // doubleword RAM access needs a step 1 strobe right after step 0
    assign second   = (tgt_sel == bus_pkg::tgt_ram) & is_dword & ~step_q;
    // RAM finishes on its late ack, others ack in the strobe cycle
    assign fin = busy & ((tgt_sel == bus_pkg::tgt_ram) ? (ram_ack & ~stb_q) : stb_q);

    assign rd_stb = stb_q & rd_pend;
    assign wr_stb = stb_q & wr_pend;
    assign step   = step_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
            hold_q  <= 1'b0;
            stb_q   <= 1'b0;
            step_q  <= 1'b0;
        end else begin
            if (start) begin
                // read wins if both enables arrive together
                rd_pend <= bus_req.read_en;
                wr_pend <= bus_req.write_en & ~bus_req.read_en;
                step_q  <= 1'b0;
                // RAM strobes at once, timer/PLIC/unmapped one cycle later
                stb_q   <= (tgt_sel == bus_pkg::tgt_ram);
                hold_q  <= (tgt_sel != bus_pkg::tgt_ram);
            end else if (hold_q) begin
                hold_q <= 1'b0;
                stb_q  <= 1'b1;
            end else if (stb_q) begin
                stb_q <= second;
                if (second) begin
                    step_q <= 1'b1;
                end
            end
            if (fin) begin
                rd_pend <= 1'b0;
                wr_pend <= 1'b0;
                step_q  <= 1'b0;
            end
        end
    end

    // read data of the selected target, unmapped gives zero
    always_comb begin
        case (tgt_sel)
            bus_pkg::tgt_ram:   sel_rdata = ram_rdata;
            bus_pkg::tgt_timer: sel_rdata = tmr_rdata;
            bus_pkg::tgt_plic:  sel_rdata = {32'b0, plic_rdata};
            default:            sel_rdata = '0;
        endcase
    end

    // held until the next read completes
    always_ff @(posedge CLOCK_50) begin
        if (fin && rd_pend) begin
            rdata_q <= sel_rdata;
        end
    end

    assign bus_rsp = '{rdata: rdata_q, read_done: ~rd_pend, write_done: ~wr_pend};

endmodule

/* verilog/periph_bus_top.sv */
`timescale 1ns/1ps

module periph_bus_top #(
    // RAM depth in 32-bit words
    parameter int ram_words = int'(soc_map_pkg::ram_bytes / 4)
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t bus_req,
    output bus_pkg::bus_rsp_t bus_rsp,
    input  logic              ext_irq,
    output logic              meip,
    output logic              msip,
    output bus_pkg::dword_t   mtime,
    output bus_pkg::dword_t   mtimecmp
);

    bus_pkg::target_t tgt_sel;
    logic             rd_stb;
    logic             wr_stb;
    logic             step;
    logic             ram_ack;
    bus_pkg::dword_t  ram_rdata;
    bus_pkg::dword_t  tmr_rdata;
    bus_pkg::word_t   plic_rdata;

    // one select level per target
    logic ram_sel;
    logic tmr_sel;
    logic plic_sel;

    assign ram_sel  = (tgt_sel == bus_pkg::tgt_ram);
    assign tmr_sel  = (tgt_sel == bus_pkg::tgt_timer);
    assign plic_sel = (tgt_sel == bus_pkg::tgt_plic);

    // decode, handshake and read data return
    bus_sequencer #(
        .ram_words(ram_words)
    ) seq_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .tgt_sel   (tgt_sel),
        .rd_stb    (rd_stb),
        .wr_stb    (wr_stb),
        .step      (step),
        .ram_ack   (ram_ack),
        .ram_rdata (ram_rdata),
        .tmr_rdata (tmr_rdata),
        .plic_rdata(plic_rdata)
    );

    scratch_ram #(
        .ram_words(ram_words)
    ) ram_i (
        .CLOCK_50(CLOCK_50),
        .req     (bus_req),
        .sel     (ram_sel),
        .rd_stb  (rd_stb),
        .wr_stb  (wr_stb),
        .step    (step),
        .ack     (ram_ack),
        .rdata   (ram_rdata)
    );

    machine_timer tmr_i (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .req     (bus_req),
        .sel     (tmr_sel),
        .wr_stb  (wr_stb),
        .mtime   (mtime),
        .mtimecmp(mtimecmp),
        .rdata   (tmr_rdata)
    );

    plic_regs plic_i (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .req     (bus_req),
        .sel     (plic_sel),
        .rd_stb  (rd_stb),
        .wr_stb  (wr_stb),
        .ext_irq (ext_irq),
        .rdata   (plic_rdata),
        .meip    (meip),
        .msip    (msip)
    );

endmodule

/* dv/periph_bus_assert.sv */
`timescale 1ns/1ps

module periph_bus_assert (
    input logic              CLOCK_50,
    input logic              KEY0,
    input bus_pkg::bus_req_t bus_req,
    input bus_pkg::bus_rsp_t bus_rsp,
    input logic              ext_irq,
    input logic              meip,
    input logic              msip,
    input logic              en0_1,
    input logic              en1_1
);

    // claim registers of the two contexts
    localparam bus_pkg::dword_t claim0_addr =
        soc_map_pkg::plic_base + soc_map_pkg::plic_claim_off;
    localparam bus_pkg::dword_t claim1_addr = claim0_addr + soc_map_pkg::plic_ctx_stride;

    // failed checks so far, read by the testbench top
    int   fail_count = 0;
    logic idle;
    logic irq_q;
    logic rd_low_q;
    logic pend_model;
    logic claim_clr;

    assign idle = bus_rsp.read_done & bus_rsp.write_done;

    // strobe cycle of a claim read, second low cycle of read_done
    // only an enabled context retires the source
    assign claim_clr = !bus_rsp.read_done && rd_low_q &&
        ((bus_req.addr == claim0_addr && en0_1) || (bus_req.addr == claim1_addr && en1_1));

    // pending bit 1 rebuilt from the pins and the bus
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_q      <= 1'b0;
            rd_low_q   <= 1'b0;
            pend_model <= 1'b0;
        end else begin
            irq_q    <= ext_irq;
            rd_low_q <= !bus_rsp.read_done;
            // new edge beats a claim in the same cycle
            if (ext_irq && !irq_q) begin
                pend_model <= 1'b1;
            end else if (claim_clr) begin
                pend_model <= 1'b0;
            end
        end
    end

    // read pulse on an idle bus drops read_done next cycle
    rd_fall: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_req.read_en && idle |=> !bus_rsp.read_done)
        else begin fail_count++; $error("read_done did not fall after read_en"); end

    // write pulse alone, read wins when both arrive
    wr_fall: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_req.write_en && !bus_req.read_en && idle |=> !bus_rsp.write_done)
        else begin fail_count++; $error("write_done did not fall after write_en"); end

    // low for at most three sampled edges, so up within 3 cycles of the enable
    rd_rise: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !bus_rsp.read_done && $past(!bus_rsp.read_done) && $past(!bus_rsp.read_done, 2)
        |=> bus_rsp.read_done)
        else begin fail_count++; $error("read_done stayed low too long"); end

    wr_rise: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !bus_rsp.write_done && $past(!bus_rsp.write_done) && $past(!bus_rsp.write_done, 2)
        |=> bus_rsp.write_done)
        else begin fail_count++; $error("write_done stayed low too long"); end

    // both done levels high while in reset
    rst_idle: assert property (@(posedge CLOCK_50) !KEY0 |-> idle)
        else begin fail_count++; $error("done levels low during reset"); end

    // claim rule on the rebuilt pending bit, only source 1 can be pending
    meip_rule: assert property (@(posedge CLOCK_50) meip == (pend_model & en0_1))
        else begin fail_count++; $error("meip differs from the claim rule"); end

    msip_rule: assert property (@(posedge CLOCK_50) msip == (pend_model & en1_1))
        else begin fail_count++; $error("msip differs from the claim rule"); end

endmodule

/* dv/tb_periph_bus.sv */
`timescale 1ns/1ps

module tb_periph_bus;

    // about seven times the ~560 cycles the tests take
    localparam int timeout_cycles = 4000;

    logic              CLOCK_50 = 1'b0;
    logic              KEY0;
    bus_pkg::bus_req_t bus_req;
    bus_pkg::bus_rsp_t bus_rsp;
    logic              ext_irq;
    logic              meip;
    logic              msip;
    bus_pkg::dword_t   mtime;
    bus_pkg::dword_t   mtimecmp;

    // byte model of the RAM, indexed by offset from ram_base
    logic [7:0] model_mem [4096];
    int         seed;
    int         mismatches = 0;
    int         failures = 0;
    int         cycles = 0;
    // expected mtime, one count per edge out of reset
    bus_pkg::dword_t mtime_ref = '0;

    always #4 CLOCK_50 = ~CLOCK_50;

    periph_bus_top dut_i (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .ext_irq (ext_irq),
        .meip    (meip),
        .msip    (msip),
        .mtime   (mtime),
        .mtimecmp(mtimecmp)
    );

    bind periph_bus_top periph_bus_assert assert_i (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .ext_irq (ext_irq),
        .meip    (meip),
        .msip    (msip),
        .en0_1   (plic_i.enable[0][1]),
        .en1_1   (plic_i.enable[1][1])
    );

    // watchdog
    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: test did not finish within %0d cycles", timeout_cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    always @(posedge CLOCK_50) begin
        if (KEY0) begin
            mtime_ref <= mtime_ref + 64'd1;
        end
    end

    // one access, called 1 ns after an edge, returns 1 ns after the done edge
    task automatic access(input logic wr, input bus_pkg::dword_t addr,
                          input bus_pkg::ls_type_t ls, input bus_pkg::dword_t wdata,
                          output bus_pkg::dword_t rdata, output int cyc);
        bus_req.addr     = addr;
        bus_req.wdata    = wdata;
        bus_req.ls_type  = ls;
        bus_req.read_en  = ~wr;
        bus_req.write_en = wr;
        @(posedge CLOCK_50);
        #1;
        bus_req.read_en  = 1'b0;
        bus_req.write_en = 1'b0;
        // cycles from the enable edge to done seen high
        cyc = 0;
        do begin
            @(posedge CLOCK_50);
            #1;
            cyc++;
        end while (!(bus_rsp.read_done && bus_rsp.write_done));
        rdata = bus_rsp.rdata;
    endtask

    task automatic compare_data(input bus_pkg::dword_t got, input bus_pkg::dword_t exp,
                                input string what);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        assert (got == exp) else begin
            failures++;
            $display("%0t: %s done rose %0d cycles after enable, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    // lanes picked by width and byte offset, sd fills two words
    task automatic model_store(input int off, input bus_pkg::ls_type_t ls,
                               input bus_pkg::dword_t wdata);
        int          base;
        logic [31:0] lanes;
        logic [3:0]  mask;
        base  = off & ~3;
        lanes = wdata[31:0] << (8 * (off % 4));
        case (ls)
            bus_pkg::ls_b: mask = 4'b0001 << (off % 4);
            bus_pkg::ls_h: mask = 4'b0011 << (off % 4);
            default: begin
                mask  = 4'b1111;
                lanes = wdata[31:0];
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) model_mem[base + i] = lanes[8*i +: 8];
        end
        if (ls == bus_pkg::ls_d) begin
            for (int i = 4; i < 8; i++) model_mem[base + i] = wdata[8*i +: 8];
        end
    endtask

    // word shifted down by the byte offset, then extended
    function automatic bus_pkg::dword_t model_load(input int off, input bus_pkg::ls_type_t ls);
        int          base;
        logic [31:0] w;
        base = off & ~3;
        w = {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
        if (ls == bus_pkg::ls_d) begin
            return {model_mem[base + 7], model_mem[base + 6],
                    model_mem[base + 5], model_mem[base + 4], w};
        end
        w = w >> (8 * (off % 4));
        case (ls)
            bus_pkg::ls_b:  return {{56{w[7]}}, w[7:0]};
            bus_pkg::ls_h:  return {{48{w[15]}}, w[15:0]};
            bus_pkg::ls_bu: return {56'b0, w[7:0]};
            bus_pkg::ls_hu: return {48'b0, w[15:0]};
            bus_pkg::ls_wu: return {32'b0, w};
            default:        return {{32{w[31]}}, w};
        endcase
    endfunction

    task automatic ram_write(input int off, input bus_pkg::ls_type_t ls,
                             input bus_pkg::dword_t wdata);
        bus_pkg::dword_t unused_rd;
        int              cyc;
        access(1'b1, soc_map_pkg::ram_base + 64'(off), ls, wdata, unused_rd, cyc);
        model_store(off, ls, wdata);
        check_latency(cyc, (ls == bus_pkg::ls_d) ? 3 : 2, "RAM store");
    endtask

    task automatic ram_check(input int off, input bus_pkg::ls_type_t ls);
        bus_pkg::dword_t d;
        int              cyc;
        access(1'b0, soc_map_pkg::ram_base + 64'(off), ls, '0, d, cyc);
        compare_data(d, model_load(off, ls), $sformatf("RAM load type %0d at %0h", ls, off));
        check_latency(cyc, (ls == bus_pkg::ls_d) ? 3 : 2, "RAM load");
    endtask

    task automatic plic_read(input bus_pkg::dword_t off, input bus_pkg::dword_t exp,
                             input string what);
        bus_pkg::dword_t d;
        int              cyc;
        access(1'b0, soc_map_pkg::plic_base + off, bus_pkg::ls_w, '0, d, cyc);
        compare_data(d, exp, what);
        check_latency(cyc, 2, "PLIC read");
    endtask

    // write, then read back through the register width
    task automatic plic_rw(input bus_pkg::dword_t off, input bus_pkg::dword_t wdata,
                           input bus_pkg::dword_t mask, input string what);
        bus_pkg::dword_t unused_rd;
        int              cyc;
        access(1'b1, soc_map_pkg::plic_base + off, bus_pkg::ls_w, wdata, unused_rd, cyc);
        check_latency(cyc, 2, "PLIC write");
        plic_read(off, wdata & mask, what);
    endtask

    // edge on ext_irq, wait for the context line, claim it
    task automatic irq_claim(input int ctx);
        bus_pkg::dword_t ctx_off;
        int              n;
        ctx_off = 64'(ctx) * soc_map_pkg::plic_ctx_stride;
        ext_irq = 1'b1;
        n = 0;
        while (!(ctx == 0 ? meip : msip) && n < 4) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        assert (ctx == 0 ? meip : msip) else begin
            failures++;
            $display("%0t: interrupt line of context %0d did not rise", $time, ctx);
        end
        plic_read(soc_map_pkg::plic_pending_off, 64'h2, "pending before claim");
        plic_read(soc_map_pkg::plic_claim_off + ctx_off, 64'h1, "claim id");
        plic_read(soc_map_pkg::plic_pending_off, 64'h0, "pending after claim");
        assert (!(ctx == 0 ? meip : msip)) else begin
            failures++;
            $display("%0t: interrupt line of context %0d stayed high after claim", $time, ctx);
        end
        ext_irq = 1'b0;
    endtask

    initial begin
        bus_pkg::dword_t d;
        bus_pkg::dword_t t0;
        int              cyc;
        int              off;
        int              errs;
        seed    = 32'h1770;
        KEY0    = 1'b0;
        bus_req = '0;
        ext_irq = 1'b0;
        repeat (10) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        @(posedge CLOCK_50);
        #1;

        // word stores, then every load width at every byte offset
        for (int n = 0; n < 4; n++) begin
            off = ($random(seed) & 32'h1ff) * 8;
            ram_write(off, bus_pkg::ls_w, 64'($random(seed)));
            for (int t = 0; t < 7; t++) begin
                for (int k = 0; k < 4; k++) begin
                    if (t != 3) ram_check(off + k, bus_pkg::ls_type_t'(t));
                end
            end
        end

        // sb and sh into a known word
        for (int n = 0; n < 8; n++) begin
            off = ($random(seed) & 32'h3ff) * 4;
            ram_write(off, bus_pkg::ls_w, 64'($random(seed)));
            ram_write(off + ($random(seed) & 3), bus_pkg::ls_b, 64'($random(seed)));
            ram_write(off + ($random(seed) & 2), bus_pkg::ls_h, 64'($random(seed)));
            ram_check(off, bus_pkg::ls_wu);
        end

        // sd and ld, plus the high word on its own
        for (int n = 0; n < 4; n++) begin
            off = ($random(seed) & 32'h1ff) * 8;
            ram_write(off, bus_pkg::ls_d, {$random(seed), $random(seed)});
            ram_check(off, bus_pkg::ls_d);
            ram_check(off + 4, bus_pkg::ls_w);
        end

        // unmapped read and write
        access(1'b0, 64'h1000_0000, bus_pkg::ls_w, '0, d, cyc);
        compare_data(d, 64'h0, "unmapped read");
        check_latency(cyc, 2, "unmapped read");
        access(1'b1, 64'h1000_0000, bus_pkg::ls_w, 64'($random(seed)), d, cyc);
        check_latency(cyc, 2, "unmapped write");

        // timer over the bus and on its output ports
        access(1'b0, soc_map_pkg::mtimecmp_addr, bus_pkg::ls_d, '0, d, cyc);
        compare_data(d, 64'h8000_0000, "mtimecmp after reset");
        compare_data(mtimecmp, 64'h8000_0000, "mtimecmp output after reset");
        check_latency(cyc, 2, "timer read");
        t0 = {$random(seed), $random(seed)};
        access(1'b1, soc_map_pkg::mtimecmp_addr, bus_pkg::ls_d, t0, d, cyc);
        compare_data(mtimecmp, t0, "mtimecmp output");
        access(1'b0, soc_map_pkg::mtimecmp_addr, bus_pkg::ls_d, '0, d, cyc);
        compare_data(d, t0, "mtimecmp");
        access(1'b0, soc_map_pkg::mtime_addr, bus_pkg::ls_d, '0, t0, cyc);
        access(1'b0, soc_map_pkg::mtime_addr, bus_pkg::ls_d, '0, d, cyc);
        compare_data(mtime, mtime_ref, "mtime output");
        assert (d > t0) else begin
            failures++;
            $display("%0t: mtime did not increase, read %0d then %0d", $time, t0, d);
        end

        // PLIC registers, then the interrupt path of both contexts
        for (int id = 1; id < 6; id++) begin
            plic_rw(64'(4 * id), 64'($random(seed)), 64'h7, "priority");
        end
        plic_rw(soc_map_pkg::plic_enable_off, 64'($random(seed)) | 64'h2,
                64'hffff_ffff, "enable ctx 0");
        plic_rw(soc_map_pkg::plic_enable_off + soc_map_pkg::plic_enable_stride,
                64'($random(seed)) & ~64'h2, 64'hffff_ffff, "enable ctx 1");
        plic_rw(soc_map_pkg::plic_threshold_off, 64'($random(seed)), 64'h7, "threshold ctx 0");
        plic_rw(soc_map_pkg::plic_threshold_off + soc_map_pkg::plic_ctx_stride,
                64'($random(seed)), 64'h7, "threshold ctx 1");
        irq_claim(0);
        plic_rw(soc_map_pkg::plic_enable_off + soc_map_pkg::plic_enable_stride,
                64'h2, 64'hffff_ffff, "enable ctx 1");
        irq_claim(1);

        @(posedge CLOCK_50);
        #1;
        errs = mismatches + failures + dut_i.assert_i.fail_count;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, dut_i.assert_i.fail_count);
        if (errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* periph_bus.f */
verilog/soc_map_pkg.sv
verilog/bus_pkg.sv
verilog/scratch_ram.sv
verilog/machine_timer.sv
verilog/plic_regs.sv
verilog/bus_sequencer.sv
verilog/periph_bus_top.sv
dv/periph_bus_assert.sv
dv/tb_periph_bus.sv

/* run_sim.sh */
#!/bin/sh
# build and run the peripheral bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f periph_bus.f \
    --top-module tb_periph_bus -Mdir obj_dir || exit 1
out=$(./obj_dir/Vtb_periph_bus +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
